// File: source/ahb_pkg.sv
// AHB-Lite bus widths and encodings; the data path is fixed at 32 bits and lock is not carried
`default_nettype none

package ahb_pkg;

  // ------------------------------------------------------------
  // Bus widths
  // ------------------------------------------------------------
  localparam int ADDR_W  = 32;
  localparam int DATA_W  = 32;
  localparam int PROT_W  = 4;
  localparam int BURST_W = 3;
  localparam int SIZE_W  = 3;

  // ------------------------------------------------------------
  // Transfer type, bit 1 high marks an active transfer
  // ------------------------------------------------------------
  typedef enum logic [1:0] {
    TR_IDLE   = 2'b00,
    TR_BUSY   = 2'b01,
    TR_NONSEQ = 2'b10,
    TR_SEQ    = 2'b11
  } htrans_t;

  // Slave response, AHB-Lite only uses OKAY and ERROR
  typedef enum logic {
    RESP_OKAY  = 1'b0,
    RESP_ERROR = 1'b1
  } hresp_t;

endpackage

`default_nettype wire

// File: source/wbuf_pkg.sv
// Write buffer state encoding and reset values; holds one transfer only, HSIZE limited to 32-bit data
`default_nettype none

package wbuf_pkg;

  // ------------------------------------------------------------
  // Downstream data phase of a posted write
  // ------------------------------------------------------------
  typedef enum logic [1:0] {
    WB_NONE    = 2'b00,
    WB_FIRST   = 2'b01,
    WB_RUNNING = 2'b10
  } wb_state_t;

  // Only the low HSIZE bits are kept, byte to word
  localparam int HOLD_SIZE_W = 2;

  // State after reset
  localparam wb_state_t WB_STATE_RST = WB_NONE;

endpackage

`default_nettype wire

// File: source/ahb_addr_hold.sv
// Address-phase hold register for one transfer; assumes upstream HREADYOUT is low while pending
`timescale 1ns/1ns
`default_nettype none

module ahb_addr_hold (
  input  logic                           HCLK,
  input  logic                           HRESETn,
  // Upstream address phase
  input  logic                           i_hsel_s,
  input  logic [ahb_pkg::ADDR_W-1:0]     i_haddr_s,
  input  logic [1:0]                     i_htrans_s,
  input  logic [ahb_pkg::SIZE_W-1:0]     i_hsize_s,
  input  logic                           i_hwrite_s,
  input  logic [ahb_pkg::BURST_W-1:0]    i_hburst_s,
  input  logic [ahb_pkg::PROT_W-1:0]     i_hprot_s,
  input  logic                           i_hready_s,
  input  logic                           i_bufferable,
  // Status from the other parts
  input  logic                           i_hready_m,
  input  wbuf_pkg::wb_state_t            i_wb_state,
  // Downstream address phase
  output logic                           o_hsel_m,
  output logic [ahb_pkg::ADDR_W-1:0]     o_haddr_m,
  output logic [1:0]                     o_htrans_m,
  output logic [ahb_pkg::SIZE_W-1:0]     o_hsize_m,
  output logic                           o_hwrite_m,
  output logic [ahb_pkg::BURST_W-1:0]    o_hburst_m,
  output logic [ahb_pkg::PROT_W-1:0]     o_hprot_m,
  output logic                           o_buf_pend,
  output logic                           o_bufferable_m
);

  import ahb_pkg::*;
  import wbuf_pkg::*;

  // Held address phase
  logic [ADDR_W-1:0]      reg_haddr;
  htrans_t                reg_htrans;
  logic [HOLD_SIZE_W-1:0] reg_hsize;
  logic                   reg_hwrite;
  logic [BURST_W-1:0]     reg_hburst;
  logic [PROT_W-1:0]      reg_hprot;
  logic                   reg_bufferable;

  logic       trans_valid;
  logic       accept;
  logic       nxt_bufferable;
  logic       running;
  logic       set_pend;
  logic       clr_pend;
  logic       hsel_sel;
  htrans_t    htrans_sel;
  logic [1:0] htrans_blk;

  // ------------------------------------------------------------
  // Hold decision
  // ------------------------------------------------------------
  assign trans_valid    = i_hsel_s & i_htrans_s[1];
  assign accept         = trans_valid & i_hready_s;
  assign nxt_bufferable = trans_valid & i_hwrite_s & i_bufferable;
  assign running        = (i_wb_state == WB_RUNNING);

  // Load when the slave side cannot take the transfer now
  assign set_pend = accept & (~i_hready_m | running);
  // A new accept during a running write refills the register instead
  assign clr_pend = i_hready_m & ~(accept & running);

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      o_buf_pend     <= 1'b0;
      reg_bufferable <= 1'b0;
    end
    else
    begin
      if (set_pend | clr_pend)
        o_buf_pend <= ~clr_pend;
      if (set_pend)
        reg_bufferable <= nxt_bufferable;
    end
  end

  // Payload only, qualified by o_buf_pend
  always_ff @(posedge HCLK)
  begin
    if (set_pend)
    begin
      reg_haddr  <= i_haddr_s;
      reg_htrans <= htrans_t'(i_htrans_s);
      reg_hsize  <= i_hsize_s[HOLD_SIZE_W-1:0];
      reg_hwrite <= i_hwrite_s;
      reg_hburst <= i_hburst_s;
      reg_hprot  <= i_hprot_s;
    end
  end

  // ------------------------------------------------------------
  // Downstream address phase mux and masking
  // ------------------------------------------------------------
  // Held transfers are always active, so HTRANS bit 1 stands in for HSEL
  assign hsel_sel   = o_buf_pend ? reg_htrans[1] : i_hsel_s;
  assign htrans_sel = o_buf_pend ? reg_htrans : htrans_t'(i_htrans_s);
  // Uncommitted live transfer kept off the bus while a write runs
  assign htrans_blk = {htrans_sel[1] & ~(running & ~o_buf_pend), htrans_sel[0]};

  assign o_hsel_m   = hsel_sel;
  assign o_htrans_m = hsel_sel ? htrans_blk : TR_IDLE;
  assign o_hburst_m = o_buf_pend ? (reg_hburst & {BURST_W{hsel_sel}})
                                 : (i_hburst_s & {BURST_W{hsel_sel}});
  assign o_haddr_m  = o_buf_pend ? reg_haddr : i_haddr_s;
  assign o_hsize_m  = o_buf_pend ? {{(SIZE_W-HOLD_SIZE_W){1'b0}}, reg_hsize} : i_hsize_s;
  assign o_hwrite_m = o_buf_pend ? reg_hwrite : i_hwrite_s;
  assign o_hprot_m  = o_buf_pend ? reg_hprot : i_hprot_s;

  // Bufferable write currently in the downstream address phase
  assign o_bufferable_m = o_buf_pend ? reg_bufferable : (nxt_bufferable & i_hready_s);

endmodule

`default_nettype wire

// File: source/ahb_write_post.sv
// Posted-write data phase tracker; a write with no wait state or a first-cycle error is not posted
`timescale 1ns/1ns
`default_nettype none

module ahb_write_post (
  input  logic                           HCLK,
  input  logic                           HRESETn,
  input  logic                           i_bufferable_m,
  input  logic                           i_hready_m,
  input  logic                           i_hreadyout_m,
  input  logic                           i_hresp_m,
  input  logic [ahb_pkg::DATA_W-1:0]     i_hwdata_s,
  output wbuf_pkg::wb_state_t            o_wb_state,
  output logic [ahb_pkg::DATA_W-1:0]     o_hwdata_m,
  output logic                           o_bwerr
);

  import ahb_pkg::*;
  import wbuf_pkg::*;

  wb_state_t         nxt_state;
  logic              start;
  logic              resp_err;
  logic [DATA_W-1:0] reg_hwdata;

  assign start    = i_bufferable_m & i_hready_m;
  assign resp_err = (i_hresp_m == RESP_ERROR);

  // ------------------------------------------------------------
  // Data phase state machine
  // ------------------------------------------------------------
  always_comb
  begin
    nxt_state = start ? WB_FIRST : WB_NONE;
    case (o_wb_state)
      // Slave stalled without error, so the write is posted
      WB_FIRST:
        if (!i_hreadyout_m && !resp_err)
          nxt_state = WB_RUNNING;
      // Stay until the slave completes, error cycles included
      WB_RUNNING:
        if (!i_hreadyout_m)
          nxt_state = WB_RUNNING;
      default:
        nxt_state = start ? WB_FIRST : WB_NONE;
    endcase
  end

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      o_wb_state <= WB_STATE_RST;
    else
      o_wb_state <= nxt_state;
  end

  // Master still drives the data in the first cycle
  always_ff @(posedge HCLK)
  begin
    if (o_wb_state == WB_FIRST)
      reg_hwdata <= i_hwdata_s;
  end

  assign o_hwdata_m = (o_wb_state == WB_RUNNING) ? reg_hwdata : i_hwdata_s;

  // ------------------------------------------------------------
  // Error pulse, set by the first cycle of a two-cycle error
  // ------------------------------------------------------------
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      o_bwerr <= 1'b0;
    else
      o_bwerr <= (o_wb_state == WB_RUNNING) & resp_err & ~i_hreadyout_m;
  end

endmodule

`default_nettype wire

// File: source/ahb_resp_merge.sv
// Upstream response and downstream ready selection; purely combinational, no state of its own
`timescale 1ns/1ns
`default_nettype none

module ahb_resp_merge (
  input  logic                i_buf_pend,
  input  wbuf_pkg::wb_state_t i_wb_state,
  input  logic                i_hreadyout_m,
  input  logic                i_hresp_m,
  input  logic                i_hready_s,
  output logic                o_hreadyout_s,
  output logic                o_hresp_s,
  output logic                o_hready_m
);

  import ahb_pkg::*;
  import wbuf_pkg::*;

  logic first;
  logic running;

  assign first   = (i_wb_state == WB_FIRST);
  assign running = (i_wb_state == WB_RUNNING);

  // ------------------------------------------------------------
  // Upstream ready, in priority order
  // ------------------------------------------------------------
  always_comb
  begin
    if (i_buf_pend)
      o_hreadyout_s = 1'b0;
    else if (first && (i_hresp_m == RESP_ERROR))
      o_hreadyout_s = 1'b0;
    else if (i_wb_state == WB_NONE)
      o_hreadyout_s = i_hreadyout_m;
    else
      // Posted write acknowledged, wait states absorbed here
      o_hreadyout_s = 1'b1;
  end

  // Errors of a posted write go to o_bwerr instead
  assign o_hresp_s = running ? RESP_OKAY : i_hresp_m;

  // Slaves follow their own ready while a posted write is active
  assign o_hready_m = (i_wb_state != WB_NONE) ? i_hreadyout_m : i_hready_s;

endmodule

`default_nettype wire

// File: source/ahb_write_buffer.sv
// Single-entry AHB-Lite write buffer; no lock, no HMASTER, no clock enable, 32-bit data only
`timescale 1ns/1ns
`default_nettype none

module ahb_write_buffer (
  input  logic                           HCLK,
  input  logic                           HRESETn,
  // Upstream slave port
  input  logic                           i_hsel_s,
  input  logic [ahb_pkg::ADDR_W-1:0]     i_haddr_s,
  input  logic [1:0]                     i_htrans_s,
  input  logic [ahb_pkg::SIZE_W-1:0]     i_hsize_s,
  input  logic                           i_hwrite_s,
  input  logic [ahb_pkg::BURST_W-1:0]    i_hburst_s,
  input  logic [ahb_pkg::PROT_W-1:0]     i_hprot_s,
  input  logic                           i_hready_s,
  input  logic [ahb_pkg::DATA_W-1:0]     i_hwdata_s,
  output logic                           o_hreadyout_s,
  output logic                           o_hresp_s,
  output logic [ahb_pkg::DATA_W-1:0]     o_hrdata_s,
  // Bufferable attribute of the upstream address phase
  input  logic                           i_bufferable,
  // Downstream master port
  output logic                           o_hsel_m,
  output logic [ahb_pkg::ADDR_W-1:0]     o_haddr_m,
  output logic [1:0]                     o_htrans_m,
  output logic [ahb_pkg::SIZE_W-1:0]     o_hsize_m,
  output logic                           o_hwrite_m,
  output logic [ahb_pkg::BURST_W-1:0]    o_hburst_m,
  output logic [ahb_pkg::PROT_W-1:0]     o_hprot_m,
  output logic                           o_hready_m,
  output logic [ahb_pkg::DATA_W-1:0]     o_hwdata_m,
  input  logic                           i_hreadyout_m,
  input  logic                           i_hresp_m,
  input  logic [ahb_pkg::DATA_W-1:0]     i_hrdata_m,
  // One-cycle pulse on a hidden write error
  output logic                           o_bwerr
);

  import wbuf_pkg::*;

  logic      buf_pend;
  logic      bufferable_m;
  wb_state_t wb_state;

  // ------------------------------------------------------------
  // Address phase path
  // ------------------------------------------------------------
  ahb_addr_hold u_addr_hold (
    .HCLK           (HCLK),
    .HRESETn        (HRESETn),
    .i_hsel_s       (i_hsel_s),
    .i_haddr_s      (i_haddr_s),
    .i_htrans_s     (i_htrans_s),
    .i_hsize_s      (i_hsize_s),
    .i_hwrite_s     (i_hwrite_s),
    .i_hburst_s     (i_hburst_s),
    .i_hprot_s      (i_hprot_s),
    .i_hready_s     (i_hready_s),
    .i_bufferable   (i_bufferable),
    .i_hready_m     (o_hready_m),
    .i_wb_state     (wb_state),
    .o_hsel_m       (o_hsel_m),
    .o_haddr_m      (o_haddr_m),
    .o_htrans_m     (o_htrans_m),
    .o_hsize_m      (o_hsize_m),
    .o_hwrite_m     (o_hwrite_m),
    .o_hburst_m     (o_hburst_m),
    .o_hprot_m      (o_hprot_m),
    .o_buf_pend     (buf_pend),
    .o_bufferable_m (bufferable_m)
  );

  // ------------------------------------------------------------
  // Data phase of posted writes
  // ------------------------------------------------------------
  ahb_write_post u_write_post (
    .HCLK           (HCLK),
    .HRESETn        (HRESETn),
    .i_bufferable_m (bufferable_m),
    .i_hready_m     (o_hready_m),
    .i_hreadyout_m  (i_hreadyout_m),
    .i_hresp_m      (i_hresp_m),
    .i_hwdata_s     (i_hwdata_s),
    .o_wb_state     (wb_state),
    .o_hwdata_m     (o_hwdata_m),
    .o_bwerr        (o_bwerr)
  );

  // Ready and response steering between the two ports
  ahb_resp_merge u_resp_merge (
    .i_buf_pend     (buf_pend),
    .i_wb_state     (wb_state),
    .i_hreadyout_m  (i_hreadyout_m),
    .i_hresp_m      (i_hresp_m),
    .i_hready_s     (i_hready_s),
    .o_hreadyout_s  (o_hreadyout_s),
    .o_hresp_s      (o_hresp_s),
    .o_hready_m     (o_hready_m)
  );

  // Read data is never buffered
  assign o_hrdata_s = i_hrdata_m;

endmodule

`default_nettype wire

// File: bench/tb_clock_gen.sv
// Free-running 4 ns clock; active-low reset released 1 ns after the fifth rising edge
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
  output logic o_hclk,
  output logic o_hresetn
);

  localparam int HALF_PERIOD  = 2;
  localparam int RESET_CYCLES = 5;

  initial
  begin
    o_hclk = 1'b0;
    forever
      #HALF_PERIOD o_hclk = ~o_hclk;
  end

  // Reset low from time zero, released away from a clock edge
  initial
  begin
    o_hresetn = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_hclk);
    #1;
    o_hresetn = 1'b1;
  end

endmodule

`default_nettype wire

// File: bench/tb_write_buffer.sv
// Directed tests with one transfer at a time; upstream HREADY loops back from HREADYOUT
`timescale 1ns/1ns
`default_nettype none

module tb_write_buffer;

  import ahb_pkg::*;

  localparam int TIMEOUT = 40;

  logic                HCLK;
  logic                HRESETn;
  // Upstream master side
  logic                i_hsel_s;
  logic [ADDR_W-1:0]   i_haddr_s;
  logic [1:0]          i_htrans_s;
  logic [SIZE_W-1:0]   i_hsize_s;
  logic                i_hwrite_s;
  logic [BURST_W-1:0]  i_hburst_s;
  logic [PROT_W-1:0]   i_hprot_s;
  logic                i_hready_s;
  logic [DATA_W-1:0]   i_hwdata_s;
  logic                o_hreadyout_s;
  logic                o_hresp_s;
  logic [DATA_W-1:0]   o_hrdata_s;
  logic                i_bufferable;
  // Downstream slave side
  logic                o_hsel_m;
  logic [ADDR_W-1:0]   o_haddr_m;
  logic [1:0]          o_htrans_m;
  logic [SIZE_W-1:0]   o_hsize_m;
  logic                o_hwrite_m;
  logic [BURST_W-1:0]  o_hburst_m;
  logic [PROT_W-1:0]   o_hprot_m;
  logic                o_hready_m;
  logic [DATA_W-1:0]   o_hwdata_m;
  logic                i_hreadyout_m;
  logic                i_hresp_m;
  logic [DATA_W-1:0]   i_hrdata_m;
  logic                o_bwerr;

  // Slave model state that the tests read mid-cycle
  int                  slv_waits;
  logic                slv_err;
  logic                dp_active;
  int                  dp_cnt;
  logic                dp_err;
  logic                dp_write;
  logic [ADDR_W-1:0]   dp_addr;
  logic [ADDR_W-1:0]   seen_addr;
  logic                seen_write;
  logic [DATA_W-1:0]   seen_wdata;

  int                  errors;
  int                  checks;
  int                  bwerr_seen;
  int                  hresp_seen;
  logic [31:0]         rng;

  tb_clock_gen u_clock_gen (
    .o_hclk    (HCLK),
    .o_hresetn (HRESETn)
  );

  ahb_write_buffer dut (
    .HCLK          (HCLK),
    .HRESETn       (HRESETn),
    .i_hsel_s      (i_hsel_s),
    .i_haddr_s     (i_haddr_s),
    .i_htrans_s    (i_htrans_s),
    .i_hsize_s     (i_hsize_s),
    .i_hwrite_s    (i_hwrite_s),
    .i_hburst_s    (i_hburst_s),
    .i_hprot_s     (i_hprot_s),
    .i_hready_s    (i_hready_s),
    .i_hwdata_s    (i_hwdata_s),
    .o_hreadyout_s (o_hreadyout_s),
    .o_hresp_s     (o_hresp_s),
    .o_hrdata_s    (o_hrdata_s),
    .i_bufferable  (i_bufferable),
    .o_hsel_m      (o_hsel_m),
    .o_haddr_m     (o_haddr_m),
    .o_htrans_m    (o_htrans_m),
    .o_hsize_m     (o_hsize_m),
    .o_hwrite_m    (o_hwrite_m),
    .o_hburst_m    (o_hburst_m),
    .o_hprot_m     (o_hprot_m),
    .o_hready_m    (o_hready_m),
    .o_hwdata_m    (o_hwdata_m),
    .i_hreadyout_m (i_hreadyout_m),
    .i_hresp_m     (i_hresp_m),
    .i_hrdata_m    (i_hrdata_m),
    .o_bwerr       (o_bwerr)
  );

  // Single-slave fabric, so HREADY is this slave's own HREADYOUT
  assign i_hready_s = o_hreadyout_s;

  // ------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Slave read data mixes in every address bit
  function automatic logic [DATA_W-1:0] read_word(input logic [ADDR_W-1:0] addr);
    return {addr[15:0], addr[31:16]} ^ 32'h5A5A_A5A5;
  endfunction

  task automatic rand_word(output logic [DATA_W-1:0] w);
    rng = xorshift32(rng);
    w   = rng;
  endtask

  task automatic check(input string name, input logic [31:0] exp_val, input logic [31:0] act_val);
    checks++;
    assert (act_val === exp_val)
    else
    begin
      errors++;
      $display("mismatch %s: expected %h, actual %h", name, exp_val, act_val);
    end
  endtask

  // Drive point 1 ns after the rising edge
  task automatic tick();
    @(posedge HCLK);
    #1;
  endtask

  task automatic drive_addr(input logic [ADDR_W-1:0] addr, input logic write, input logic buf_en);
    i_hsel_s     = 1'b1;
    i_htrans_s   = TR_NONSEQ;
    i_haddr_s    = addr;
    i_hwrite_s   = write;
    i_bufferable = buf_en;
  endtask

  task automatic drive_idle();
    i_hsel_s     = 1'b0;
    i_htrans_s   = TR_IDLE;
    i_bufferable = 1'b0;
  endtask

  // Counts upstream wait cycles mid-cycle and returns at the ready cycle
  task automatic wait_upstream(input string name, input logic follow, output int low);
    low = 0;
    @(negedge HCLK);
    while (!o_hreadyout_s && low < TIMEOUT)
    begin
      if (follow)
        check({name, " ready"}, i_hreadyout_m, o_hreadyout_s);
      low++;
      @(negedge HCLK);
    end
    if (follow)
      check({name, " ready"}, i_hreadyout_m, o_hreadyout_s);
    assert (low < TIMEOUT)
    else
    begin
      errors++;
      $display("%s: upstream HREADYOUT never went high", name);
    end
  endtask

  // Downstream write data must hold until the slave is ready
  // Slaves see their own ready while the posted write runs
  task automatic wait_slave_done(input string name, input logic [DATA_W-1:0] exp_wdata);
    int n;
    n = 0;
    @(negedge HCLK);
    check({name, " hwdata_m"}, exp_wdata, o_hwdata_m);
    check({name, " hready_m"}, i_hreadyout_m, o_hready_m);
    while (!i_hreadyout_m && n < TIMEOUT)
    begin
      n++;
      @(negedge HCLK);
      check({name, " hwdata_m"}, exp_wdata, o_hwdata_m);
      check({name, " hready_m"}, i_hreadyout_m, o_hready_m);
    end
    assert (n < TIMEOUT)
    else
    begin
      errors++;
      $display("%s: downstream slave never completed", name);
    end
  endtask

  // ------------------------------------------------------------
  // Downstream slave model
  // ------------------------------------------------------------
  always @(posedge HCLK)
  begin
    // Data phase ends on this edge when the slave was ready
    if (dp_active && i_hreadyout_m && dp_write)
      seen_wdata = o_hwdata_m;
    if (!dp_active || i_hreadyout_m)
    begin
      dp_active = o_hsel_m && o_htrans_m[1] && o_hready_m;
      if (dp_active)
      begin
        dp_cnt     = slv_waits;
        dp_err     = slv_err;
        dp_write   = o_hwrite_m;
        dp_addr    = o_haddr_m;
        seen_addr  = o_haddr_m;
        seen_write = o_hwrite_m;
      end
    end
    else
      dp_cnt = dp_cnt - 1;
    #1;
    i_hreadyout_m = !dp_active || (dp_cnt == 0);
    // Two-cycle error as low ready then high ready
    i_hresp_m     = dp_active && dp_err && (dp_cnt <= 1);
    i_hrdata_m    = (dp_active && !dp_write && dp_cnt == 0) ? read_word(dp_addr) : '0;
  end

  always @(negedge HCLK)
  begin
    if (o_bwerr === 1'b1)
      bwerr_seen++;
    if (o_hresp_s === 1'b1)
      hresp_seen++;
  end

  // ------------------------------------------------------------
  // Tests
  // ------------------------------------------------------------
  task automatic read_pass_through();
    int low;
    slv_waits = 2;
    drive_addr(32'h0000_2A40, 1'b0, 1'b0);
    i_hburst_s = 3'b001;
    @(negedge HCLK);
    check("read_pass hsel_m", 1'b1, o_hsel_m);
    check("read_pass haddr_m", 32'h0000_2A40, o_haddr_m);
    check("read_pass htrans_m", TR_NONSEQ, o_htrans_m);
    check("read_pass hwrite_m", 1'b0, o_hwrite_m);
    check("read_pass hsize_m", 3'b010, o_hsize_m);
    check("read_pass hburst_m", 3'b001, o_hburst_m);
    check("read_pass hprot_m", 4'b0011, o_hprot_m);
    tick();
    drive_idle();
    i_hburst_s = '0;
    wait_upstream("read_pass", 1'b1, low);
    check("read_pass waits", 2, low);
    check("read_pass hrdata", read_word(32'h0000_2A40), o_hrdata_s);
    tick();
  endtask

  task automatic write_through();
    logic [DATA_W-1:0] wd;
    int low;
    rand_word(wd);
    slv_waits = 3;
    drive_addr(32'h0000_3100, 1'b1, 1'b0);
    tick();
    drive_idle();
    i_hwdata_s = wd;
    wait_upstream("write_through", 1'b1, low);
    check("write_through waits", 3, low);
    tick();
    check("write_through wdata", wd, seen_wdata);
  endtask

  task automatic posted_write();
    logic [DATA_W-1:0] wd;
    logic [DATA_W-1:0] other;
    rand_word(wd);
    rand_word(other);
    slv_waits = 4;
    drive_addr(32'h0000_4008, 1'b1, 1'b1);
    tick();
    drive_idle();
    i_hwdata_s = wd;
    @(negedge HCLK);
    check("posted ack", 1'b1, o_hreadyout_s);
    tick();
    // Master has moved on and the captured word must stay downstream
    i_hwdata_s = other;
    wait_slave_done("posted", wd);
    tick();
    check("posted wdata", wd, seen_wdata);
  endtask

  task automatic read_held_behind_write();
    logic [DATA_W-1:0] wd;
    int low;
    rand_word(wd);
    slv_waits = 3;
    slv_err   = 1'b0;
    drive_addr(32'h0000_5000, 1'b1, 1'b1);
    tick();
    i_hwdata_s = wd;
    drive_addr(32'h0000_5A0C, 1'b0, 1'b0);
    @(negedge HCLK);
    check("hold_read write ack", 1'b1, o_hreadyout_s);
    tick();
    slv_waits = 1;
    drive_idle();
    rand_word(i_hwdata_s);
    // Held for the 3 write waits and then 1 read wait
    wait_upstream("hold_read", 1'b0, low);
    check("hold_read waits", 4, low);
    check("hold_read haddr", 32'h0000_5A0C, seen_addr);
    check("hold_read hwrite", 1'b0, seen_write);
    check("hold_read hrdata", read_word(32'h0000_5A0C), o_hrdata_s);
    tick();
    check("hold_read wdata", wd, seen_wdata);
  endtask

  task automatic posted_write_error();
    logic [DATA_W-1:0] wd;
    rand_word(wd);
    slv_waits  = 3;
    slv_err    = 1'b1;
    bwerr_seen = 0;
    hresp_seen = 0;
    drive_addr(32'h0000_6010, 1'b1, 1'b1);
    tick();
    drive_idle();
    i_hwdata_s = wd;
    @(negedge HCLK);
    check("bw_error ack", 1'b1, o_hreadyout_s);
    wait_slave_done("bw_error", wd);
    tick();
    tick();
    check("bw_error hresp cycles", 0, hresp_seen);
    check("bw_error bwerr cycles", 1, bwerr_seen);
    // Error in the first data cycle goes upstream
    slv_waits  = 1;
    bwerr_seen = 0;
    drive_addr(32'h0000_6020, 1'b1, 1'b1);
    tick();
    drive_idle();
    @(negedge HCLK);
    check("first_error hreadyout", 1'b0, o_hreadyout_s);
    check("first_error hresp", 1'b1, o_hresp_s);
    tick();
    slv_err = 1'b0;
    @(negedge HCLK);
    check("first_error hreadyout end", 1'b1, o_hreadyout_s);
    check("first_error hresp end", 1'b1, o_hresp_s);
    tick();
    check("first_error bwerr cycles", 0, bwerr_seen);
  endtask

  task automatic unselected_masking();
    i_hsel_s   = 1'b0;
    i_htrans_s = TR_NONSEQ;
    i_hburst_s = 3'b011;
    @(negedge HCLK);
    check("masking htrans_m", TR_IDLE, o_htrans_m);
    check("masking hburst_m", 3'b000, o_hburst_m);
    tick();
    drive_idle();
    i_hburst_s = '0;
    tick();
  endtask

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------
  initial
  begin
    int n;
    i_hsel_s      = 1'b0;
    i_haddr_s     = '0;
    i_htrans_s    = TR_IDLE;
    i_hsize_s     = 3'b010;
    i_hwrite_s    = 1'b0;
    i_hburst_s    = '0;
    i_hprot_s     = 4'b0011;
    i_hwdata_s    = '0;
    i_bufferable  = 1'b0;
    i_hreadyout_m = 1'b1;
    i_hresp_m     = 1'b0;
    i_hrdata_m    = '0;
    dp_active     = 1'b0;
    slv_waits     = 0;
    slv_err       = 1'b0;
    errors        = 0;
    checks        = 0;
    rng           = 32'd49242;
    n = 0;
    while (HRESETn !== 1'b1 && n < TIMEOUT)
    begin
      n++;
      @(posedge HCLK);
    end
    assert (n < TIMEOUT)
    else
    begin
      errors++;
      $display("reset was never released");
    end
    tick();
    read_pass_through();
    write_through();
    posted_write();
    read_held_behind_write();
    posted_write_error();
    unselected_masking();
    $display("errors %0d of %0d checks", errors, checks);
    if (errors == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
source/ahb_pkg.sv
source/wbuf_pkg.sv
source/ahb_addr_hold.sv
source/ahb_write_post.sv
source/ahb_resp_merge.sv
source/ahb_write_buffer.sv
bench/tb_clock_gen.sv
bench/tb_write_buffer.sv
